// ==== pad_ring_cfg.svh ====
`ifndef PAD_RING_CFG_SVH
`define PAD_RING_CFG_SVH

// Pad ring widths, fixed by the chip pin-out

// Ports A and B are one byte wide each
`define PAD_PORT_WIDTH 8

// Debug serial bus address into a pattern buffer
`define PAD_SADDR_WIDTH 3

// Instruction memory load bus
`define IMEM_ADR_WIDTH 10
`define IMEM_DATA_WIDTH 40

// The byte shifter holds one address and one data word
`define IMEM_SHIFT_WIDTH (`IMEM_ADR_WIDTH + `IMEM_DATA_WIDTH)

// Clock-out divider
// Clock-out is the top counter bit, so clk_int is divided by 2**bits
`define CLK_OUT_DIV_BITS 3

`endif

// ==== pat_mode_pkg.sv ====
`default_nettype none

`include "pad_ring_cfg.svh"

package pat_mode_pkg;

	// Operating mode, read straight from the two mode pins
	typedef enum logic [1:0] {
		MODE_RESET   = 2'd0,
		MODE_DEBUG   = 2'd1,
		MODE_RUN     = 2'd2,
		MODE_MEMLOAD = 2'd3
	} pat_mode_e;

	// Port B pad control
	// The low nibble is an input in every mode but RUN,
	// the high nibble always drives
	typedef struct packed {
		logic [`PAD_PORT_WIDTH-1:0] value;
		logic [`PAD_PORT_WIDTH-1:0] oe;
	} port_b_ctrl_t;

endpackage

`default_nettype wire

// ==== pat_bus_pkg.sv ====
`default_nettype none

`include "pad_ring_cfg.svh"

package pat_bus_pkg;

	// Debug serial port of one pattern buffer
	// Only one of the two buffers is addressed at a time
	typedef struct packed {
		logic                        sclk;
		logic                        ssel;
		logic                        sin;
		logic [`PAD_SADDR_WIDTH-1:0] saddr;
	} serial_port_t;

	// Instruction memory load bus into the core
	// adr and data come from the byte shifter, write from port B bit 1
	typedef struct packed {
		logic [`IMEM_ADR_WIDTH-1:0]  adr;
		logic [`IMEM_DATA_WIDTH-1:0] data;
		logic                        write;
	} imem_write_t;

endpackage

`default_nettype wire

// ==== mode_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pad_ring_cfg.svh"

module mode_decoder (
	input  wire pat_mode_pkg::pat_mode_e   mode,
	input  wire [`PAD_PORT_WIDTH-1:0]      pad_a_in,
	input  wire [`PAD_PORT_WIDTH-1:0]      pad_b_in,
	input  wire                            sout_low,
	input  wire                            sout_high,
	input  wire [`PAD_PORT_WIDTH-1:0]      core_outputs,
	output logic                           mode_is_reset,
	output pat_bus_pkg::serial_port_t      dbg_low,
	output pat_bus_pkg::serial_port_t      dbg_high,
	output logic                           reset_pat,
	output logic                           reset_patternbuf_low,
	output logic                           reset_patternbuf_high,
	output pat_mode_pkg::port_b_ctrl_t     pad_b,
	output logic                           imem_clock,
	output logic                           imem_write
);
	import pat_mode_pkg::*;
	import pat_bus_pkg::*;

	logic         is_debug;
	logic         is_run;
	logic         buf_select;
	logic         sout_sel;
	serial_port_t dbg_port;

	assign mode_is_reset = (mode == MODE_RESET);
	assign is_debug = (mode == MODE_DEBUG);
	assign is_run = (mode == MODE_RUN);

	// Port A field map in DEBUG
	// Bit 6 picks the high buffer, bit 7 was scan-in and is unused
	assign dbg_port.sclk = pad_a_in[0];
	assign dbg_port.ssel = pad_a_in[1];
	assign dbg_port.sin = pad_a_in[2];
	assign dbg_port.saddr = pad_a_in[5:3];
	assign buf_select = pad_a_in[6];

	// Only the selected buffer sees the serial bus
	always_comb begin
		dbg_low = '0;
		dbg_high = '0;
		if (is_debug) begin
			if (buf_select) begin
				dbg_high = dbg_port;
			end else begin
				dbg_low = dbg_port;
			end
		end
	end

	assign sout_sel = buf_select ? sout_high : sout_low;

	// Core and buffer resets
	always_comb begin
		case (mode)
			MODE_DEBUG: begin
				reset_pat = pad_b_in[2];
				reset_patternbuf_high = pad_b_in[1];
				reset_patternbuf_low = pad_b_in[0];
			end
			MODE_RUN: begin
				reset_pat = 1'b0;
				reset_patternbuf_high = 1'b0;
				reset_patternbuf_low = 1'b0;
			end
			// RESET and MEMLOAD hold everything in reset
			default: begin
				reset_pat = 1'b1;
				reset_patternbuf_high = 1'b1;
				reset_patternbuf_low = 1'b1;
			end
		endcase
	end

	// Port B drive
	// In DEBUG bits 0 to 3 pull up the reset inputs and bit 4 returns sout
	assign pad_b.oe = {4'hf, {4{is_run}}};
	assign pad_b.value = is_debug ? {core_outputs[7:5], sout_sel, 4'hf} : core_outputs;

	// Load strobes from port B, gated to MEMLOAD
	assign imem_clock = (mode == MODE_MEMLOAD) ? pad_b_in[0] : 1'b0;
	assign imem_write = (mode == MODE_MEMLOAD) ? pad_b_in[1] : 1'b0;

endmodule

`default_nettype wire

// ==== imem_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pad_ring_cfg.svh"

module imem_loader (
	input  wire                            clk_int,
	input  wire                            mode_is_reset,
	input  wire [`PAD_PORT_WIDTH-1:0]      pad_a_in,
	input  wire                            imem_clock,
	input  wire                            imem_write,
	output logic [`PAD_PORT_WIDTH-1:0]     core_inputs,
	output pat_bus_pkg::imem_write_t       imem_wr
);
	logic [`PAD_PORT_WIDTH-1:0]  port_a_meta;
	logic [`PAD_PORT_WIDTH-1:0]  port_a_sync;
	logic                        imem_clock_meta;
	logic                        imem_clock_sync;
	logic                        imem_clock_prev;
	logic                        imem_write_meta;
	logic                        imem_write_sync;
	logic                        load_edge;
	logic [`IMEM_SHIFT_WIDTH-1:0] shifter;

	// Two-flop synchroniser for the port A data byte
	always_ff @(posedge clk_int) begin
		port_a_meta <= pad_a_in;
		port_a_sync <= port_a_meta;
	end

	// Load strobes are synchronised the same way
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			imem_clock_meta <= 1'b0;
			imem_clock_sync <= 1'b0;
			imem_clock_prev <= 1'b0;
			imem_write_meta <= 1'b0;
			imem_write_sync <= 1'b0;
		end else begin
			imem_clock_meta <= imem_clock;
			imem_clock_sync <= imem_clock_meta;
			imem_clock_prev <= imem_clock_sync;
			imem_write_meta <= imem_write;
			imem_write_sync <= imem_write_meta;
		end
	end

	// Rising edge of the load clock, one cycle wide
	assign load_edge = imem_clock_sync & ~imem_clock_prev;

	// New byte enters at the bottom, oldest byte falls off the top
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			shifter <= '0;
		end else if (load_edge) begin
			shifter <= {shifter[`IMEM_SHIFT_WIDTH-`PAD_PORT_WIDTH-1:0], port_a_sync};
		end
	end

	assign core_inputs = port_a_sync;

	// Address sits above the data word
	assign imem_wr.adr = shifter[`IMEM_SHIFT_WIDTH-1:`IMEM_DATA_WIDTH];
	assign imem_wr.data = shifter[`IMEM_DATA_WIDTH-1:0];
	assign imem_wr.write = imem_write_sync;

endmodule

`default_nettype wire

// ==== pat_clock_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pad_ring_cfg.svh"

module pat_clock_ctrl (
	input  wire                          clk_int,
	input  wire                          pad_clock_in,
	input  wire                          mode_is_reset,
	input  wire pat_mode_pkg::pat_mode_e mode,
	input  wire                          div_in,
	output logic                         pat_clock_division,
	output logic                         clock_pat,
	output logic                         pad_clock_out
);
	import pat_mode_pkg::*;

	logic                         pat_clock_slow;
	logic [`CLK_OUT_DIV_BITS-1:0] clk_div;

	// Division flag lives in the external clock domain
	// Half rate after reset, reloaded from port B bit 3 in DEBUG
	always_ff @(posedge pad_clock_in or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			pat_clock_division <= 1'b1;
		end else if (mode == MODE_DEBUG) begin
			pat_clock_division <= div_in;
		end
	end

	// Half-rate toggle
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			pat_clock_slow <= 1'b0;
		end else begin
			pat_clock_slow <= ~pat_clock_slow;
		end
	end

	// Plain select, not glitch free
	assign clock_pat = pat_clock_division ? pat_clock_slow : clk_int;

	// Free-running divider for the clock-out pin
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			clk_div <= '0;
		end else begin
			clk_div <= clk_div + 1'b1;
		end
	end

	assign pad_clock_out = clk_div[`CLK_OUT_DIV_BITS-1];

endmodule

`default_nettype wire

// ==== pad_ring_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pad_ring_cfg.svh"

module pad_ring_top (
	input  wire                            clk_int,
	input  wire pat_mode_pkg::pat_mode_e   pad_modesel,
	input  wire                            pad_clock_in,
	input  wire [`PAD_PORT_WIDTH-1:0]      pad_a_in,
	input  wire [`PAD_PORT_WIDTH-1:0]      pad_b_in,
	input  wire                            sout_low,
	input  wire                            sout_high,
	input  wire [`PAD_PORT_WIDTH-1:0]      core_outputs,
	output pat_mode_pkg::port_b_ctrl_t     pad_b,
	output logic                           pad_clock_out,
	output pat_bus_pkg::serial_port_t      dbg_low,
	output pat_bus_pkg::serial_port_t      dbg_high,
	output logic                           reset_pat,
	output logic                           reset_patternbuf_low,
	output logic                           reset_patternbuf_high,
	output logic [`PAD_PORT_WIDTH-1:0]     core_inputs,
	output pat_bus_pkg::imem_write_t       imem_wr,
	output logic                           clock_pat,
	output logic                           pat_clock_division
);
	// RESET mode doubles as the asynchronous reset
	logic mode_is_reset;

	// Load strobes, already gated to MEMLOAD
	logic imem_clock;
	logic imem_write;

	// Mode decode, debug bus routing, resets and port B
	mode_decoder u_mode_decoder (
		.mode                  (pad_modesel),
		.pad_a_in              (pad_a_in),
		.pad_b_in              (pad_b_in),
		.sout_low              (sout_low),
		.sout_high             (sout_high),
		.core_outputs          (core_outputs),
		.mode_is_reset         (mode_is_reset),
		.dbg_low               (dbg_low),
		.dbg_high              (dbg_high),
		.reset_pat             (reset_pat),
		.reset_patternbuf_low  (reset_patternbuf_low),
		.reset_patternbuf_high (reset_patternbuf_high),
		.pad_b                 (pad_b),
		.imem_clock            (imem_clock),
		.imem_write            (imem_write)
	);

	// Port A into the core and the imem byte loader
	imem_loader u_imem_loader (
		.clk_int       (clk_int),
		.mode_is_reset (mode_is_reset),
		.pad_a_in      (pad_a_in),
		.imem_clock    (imem_clock),
		.imem_write    (imem_write),
		.core_inputs   (core_inputs),
		.imem_wr       (imem_wr)
	);

	// Pattern clock select and clock-out divider
	// Port B bit 3 carries the division setting in DEBUG
	pat_clock_ctrl u_pat_clock_ctrl (
		.clk_int            (clk_int),
		.pad_clock_in       (pad_clock_in),
		.mode_is_reset      (mode_is_reset),
		.mode               (pad_modesel),
		.div_in             (pad_b_in[3]),
		.pat_clock_division (pat_clock_division),
		.clock_pat          (clock_pat),
		.pad_clock_out      (pad_clock_out)
	);

endmodule

`default_nettype wire

// ==== tb_pad_ring_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pad_ring_chk (
	input wire                             clk_int,
	input wire pat_mode_pkg::pat_mode_e    pad_modesel,
	input wire                             reset_pat,
	input wire                             reset_patternbuf_low,
	input wire                             reset_patternbuf_high,
	input wire pat_bus_pkg::serial_port_t  dbg_low,
	input wire pat_bus_pkg::serial_port_t  dbg_high,
	input wire pat_mode_pkg::port_b_ctrl_t pad_b,
	input wire pat_bus_pkg::imem_write_t   imem_wr
);
	import pat_mode_pkg::*;

	int assert_failures = 0;

	// Core and both buffers held in reset while the mode pins say RESET
	resets_in_reset: assert property (@(posedge clk_int)
		pad_modesel == MODE_RESET |-> reset_pat && reset_patternbuf_low && reset_patternbuf_high)
	else begin
		$error("resets not all high in MODE_RESET");
		assert_failures++;
	end

	// Only one pattern buffer is clocked at a time
	one_sclk: assert property (@(posedge clk_int) !(dbg_low.sclk && dbg_high.sclk))
	else begin
		$error("both debug serial clocks high");
		assert_failures++;
	end

	// Low nibble of port B drives only in RUN
	low_oe_in_run: assert property (@(posedge clk_int)
		pad_b.oe[3:0] != 4'h0 |-> pad_modesel == MODE_RUN)
	else begin
		$error("port B low nibble driven outside MODE_RUN");
		assert_failures++;
	end

	// Write strobe passes a two-flop synchroniser, so MEMLOAD leads it by two cycles
	write_after_memload: assert property (@(posedge clk_int)
		imem_wr.write |-> $past(pad_modesel, 2) == MODE_MEMLOAD)
	else begin
		$error("imem write without MODE_MEMLOAD two cycles earlier");
		assert_failures++;
	end

endmodule

bind pad_ring_top tb_pad_ring_chk u_chk (
	.clk_int               (clk_int),
	.pad_modesel           (pad_modesel),
	.reset_pat             (reset_pat),
	.reset_patternbuf_low  (reset_patternbuf_low),
	.reset_patternbuf_high (reset_patternbuf_high),
	.dbg_low               (dbg_low),
	.dbg_high              (dbg_high),
	.pad_b                 (pad_b),
	.imem_wr               (imem_wr)
);

`default_nettype wire

// ==== tb_pad_ring.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pad_ring_cfg.svh"

module tb_pad_ring;
	import pat_mode_pkg::*;
	import pat_bus_pkg::*;

	logic                       clk_int;
	logic                       pad_clock_in;
	pat_mode_e                  pad_modesel;
	logic [`PAD_PORT_WIDTH-1:0] pad_a_in;
	logic [`PAD_PORT_WIDTH-1:0] pad_b_in;
	logic                       sout_low;
	logic                       sout_high;
	logic [`PAD_PORT_WIDTH-1:0] core_outputs;
	port_b_ctrl_t               pad_b;
	logic                       pad_clock_out;
	serial_port_t               dbg_low;
	serial_port_t               dbg_high;
	logic                       reset_pat;
	logic                       reset_patternbuf_low;
	logic                       reset_patternbuf_high;
	logic [`PAD_PORT_WIDTH-1:0] core_inputs;
	imem_write_t                imem_wr;
	logic                       clock_pat;
	logic                       pat_clock_division;

	logic [31:0] rng;
	logic [7:0]  byte_hist[$];
	int          errors;
	int          errors_at_start;
	int          tests_run;
	int          tests_failed;
	logic        monitor_on;
	logic [7:0]  a_d1;
	logic [7:0]  a_d2;
	logic        w_d1;
	logic        w_d2;

	pad_ring_top DUT (.*);

	initial begin
		clk_int = 1'b0;
		forever #2 clk_int = ~clk_int;
	end

	initial begin
		pad_clock_in = 1'b0;
		forever #6 pad_clock_in = ~pad_clock_in;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] next_byte();
		rng = xorshift32(rng);
		return rng[7:0];
	endfunction

	// Last seven bytes form a 56-bit window, the shifter keeps its low 50 bits
	function automatic logic [`IMEM_SHIFT_WIDTH-1:0] ref_shifter(input logic [7:0] hist[$]);
		logic [55:0] window;
		int          first;
		window = '0;
		first = (hist.size() > 7) ? hist.size() - 7 : 0;
		for (int i = first; i < hist.size(); i++) begin
			window = {window[47:0], hist[i]};
		end
		return window[`IMEM_SHIFT_WIDTH-1:0];
	endfunction

	// Expected {reset_pat, reset_patternbuf_high, reset_patternbuf_low}
	function automatic logic [2:0] ref_resets(input pat_mode_e mode, input logic [7:0] b);
		case (mode)
			MODE_DEBUG: return b[2:0];
			MODE_RUN: return 3'b000;
			default: return 3'b111;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
			$display("test %-14s failed, %0d errors", name, errors - errors_at_start);
		end else begin
			$display("test %-14s ok", name);
		end
		errors_at_start = errors;
	endtask

	// Counts clk_int cycles up to the next rise of pad_clock_out
	task automatic wait_clock_out_rise(output int cycles);
		logic prev;
		prev = pad_clock_out;
		cycles = 0;
		while (cycles < 20) begin
			@(negedge clk_int);
			cycles++;
			if (!prev && pad_clock_out) begin
				return;
			end
			prev = pad_clock_out;
		end
		$display("pad_clock_out did not rise within 20 clk_int cycles");
		errors++;
	endtask

	task automatic wait_division(input logic level, input int limit);
		for (int i = 0; i < limit; i++) begin
			@(negedge clk_int);
			if (pat_clock_division === level) begin
				return;
			end
		end
		$display("pat_clock_division did not reach %0d within %0d clk_int cycles", level, limit);
		errors++;
	endtask

	// Synchronised paths trail the pins by two rising edges
	always @(posedge clk_int) begin
		if (monitor_on) begin
			check_value("core_inputs", core_inputs, a_d2);
			if (pad_modesel != MODE_RESET) begin
				check_value("imem_wr.write", imem_wr.write, w_d2);
			end
		end
		a_d2 = a_d1;
		a_d1 = pad_a_in;
		w_d2 = w_d1;
		w_d1 = (pad_modesel == MODE_MEMLOAD) && pad_b_in[1];
	end

	initial begin
		logic [7:0] b;
		logic [7:0] w;
		logic [5:0] sel;
		logic       prev_pat;
		int         cycles;
		rng = 32'hdde;
		errors = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		monitor_on = 1'b0;
		pad_modesel = MODE_RESET;
		pad_a_in = '0;
		pad_b_in = '0;
		sout_low = 1'b0;
		sout_high = 1'b0;
		core_outputs = '0;
		repeat (16) @(negedge clk_int);
		monitor_on = 1'b1;

		for (int m = 0; m < 4; m++) begin
			repeat (4) begin
				@(negedge clk_int);
				pad_modesel = pat_mode_e'(m);
				pad_b_in = next_byte();
				@(posedge clk_int);
				check_value("resets", {reset_pat, reset_patternbuf_high, reset_patternbuf_low},
					ref_resets(pad_modesel, pad_b_in));
			end
		end
		end_test("resets");

		repeat (8) begin
			@(negedge clk_int);
			pad_modesel = MODE_DEBUG;
			pad_a_in = next_byte();
			b = next_byte();
			sout_low = b[0];
			sout_high = b[1];
			@(posedge clk_int);
			sel = {pad_a_in[0], pad_a_in[1], pad_a_in[2], pad_a_in[5:3]};
			check_value("dbg_high", dbg_high, pad_a_in[6] ? sel : 6'd0);
			check_value("dbg_low", dbg_low, pad_a_in[6] ? 6'd0 : sel);
			check_value("pad_b.value[4:0]", pad_b.value[4:0],
				{pad_a_in[6] ? sout_high : sout_low, 4'hf});
		end
		@(negedge clk_int);
		pad_modesel = MODE_RUN;
		pad_a_in = next_byte() | 8'h01;
		@(posedge clk_int);
		check_value("dbg_low", dbg_low, 6'd0);
		check_value("dbg_high", dbg_high, 6'd0);
		end_test("debug_routing");

		repeat (4) begin
			@(negedge clk_int);
			pad_modesel = MODE_RUN;
			core_outputs = next_byte();
			@(posedge clk_int);
			check_value("pad_b.value", pad_b.value, core_outputs);
			check_value("pad_b.oe", pad_b.oe, 8'hff);
		end
		@(negedge clk_int);
		pad_modesel = MODE_MEMLOAD;
		pad_b_in = '0;
		@(posedge clk_int);
		check_value("pad_b.oe[3:0]", pad_b.oe[3:0], 4'h0);
		end_test("port_b_drive");

		@(negedge clk_int);
		pad_modesel = MODE_RESET;
		repeat (4) @(negedge clk_int);
		pad_modesel = MODE_MEMLOAD;
		byte_hist.delete();
		for (int n = 0; n < 9; n++) begin
			b = next_byte();
			w = next_byte();
			pad_a_in = b;
			pad_b_in = {6'd0, w[0], 1'b0};
			byte_hist.push_back(b);
			repeat (2) @(negedge clk_int);
			pad_b_in[0] = 1'b1;
			repeat (4) @(negedge clk_int);
			pad_b_in[0] = 1'b0;
			repeat (4) @(negedge clk_int);
			check_value("imem_wr.adr/data", {imem_wr.adr, imem_wr.data}, ref_shifter(byte_hist));
		end
		pad_b_in = '0;
		@(negedge clk_int);
		end_test("memory_load");

		pad_modesel = MODE_RESET;
		repeat (4) @(negedge clk_int);
		pad_modesel = MODE_RUN;
		@(negedge clk_int);
		check_value("pat_clock_division", pat_clock_division, 1'b1);
		wait_clock_out_rise(cycles);
		wait_clock_out_rise(cycles);
		check_value("pad_clock_out period", cycles, 8);
		// Division reload runs on pad_clock_in, three clk_int cycles per period
		pad_modesel = MODE_DEBUG;
		pad_b_in = 8'h00;
		wait_division(1'b0, 9);
		// At full rate clock_pat is clk_int itself
		@(posedge clk_int);
		#1;
		check_value("clock_pat", clock_pat, 1'b1);
		@(negedge clk_int);
		#1;
		check_value("clock_pat", clock_pat, 1'b0);
		@(negedge clk_int);
		pad_b_in = 8'h08;
		wait_division(1'b1, 9);
		// At half rate clock_pat flips once per clk_int cycle
		prev_pat = clock_pat;
		repeat (4) begin
			@(negedge clk_int);
			check_value("clock_pat", clock_pat, !prev_pat);
			prev_pat = clock_pat;
		end
		end_test("pattern_clock");

		errors += DUT.u_chk.assert_failures;
		$display("tests %0d, failed %0d, assertion failures %0d, errors %0d",
			tests_run, tests_failed, DUT.u_chk.assert_failures, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
pat_mode_pkg.sv
pat_bus_pkg.sv
mode_decoder.sv
imem_loader.sv
pat_clock_ctrl.sv
pad_ring_top.sv
tb_pad_ring_chk.sv
tb_pad_ring.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = tb_pad_ring
FILELIST   = files.f
OBJ_DIR    = obj_dir
RUN_ARGS   = +verilator+error+limit+1000
PASS_MSG   = >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
